//--- hdl/mon_break_point.sv
`timescale 1ns/10ps

module mon_break_point (
	input  logic clk,
	input  logic rst_n,
	input  logic bp_load,
	input  mon_pkg::mon_word_u word,
	input  logic [31:0] pc_data,
	input  logic cpu_run_state,
	output logic bp_hit
);
	import mon_pkg::*;

	logic [word_w-3:0] bp_addr;
	logic bp_en;

	// bit 0 of the typed address turns the breakpoint off
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bp_addr <= '0;
			bp_en <= 1'b0;
		end else if (bp_load) begin
			bp_addr <= word.bp.addr;
			bp_en <= ~word.bp.disabled;
		end
	end

	// word address compare, only while running
	assign bp_hit = cpu_run_state && bp_en && (bp_addr == pc_data[31:2]);

endmodule

//--- hdl/mon_char_decode.sv
`timescale 1ns/10ps

module mon_char_decode (
	input  logic clk,
	input  logic rst_n,
	input  logic [7:0] rx_char,
	input  logic rx_valid,
	output mon_pkg::char_info_t info
);
	import mon_pkg::*;

	logic [7:0] char_q;
	logic strobe_q;
	cmd_code_t char_code;
	logic char_is_hex;
	logic [3:0] char_nibble;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			char_q <= 8'h00;
			strobe_q <= 1'b0;
		end else begin
			strobe_q <= rx_valid;
			if (rx_valid) begin
				char_q <= rx_char;
			end
		end
	end

	// command table
	always_comb begin
		case (char_q)
			8'h67: char_code = cmd_go;        // g
			8'h03: char_code = cmd_quit;      // ctrl-c
			8'h77: char_code = cmd_write;     // w
			8'h72: char_code = cmd_read;      // r
			8'h73: char_code = cmd_stop;      // s
			8'h6a: char_code = cmd_print_pc;  // j
			8'h0d: char_code = cmd_crlf;      // CR
			default: char_code = cmd_none;
		endcase
	end

	// hex digits, lower case letters only
	always_comb begin
		char_is_hex = 1'b0;
		char_nibble = 4'h0;
		if (char_q >= 8'h30 && char_q <= 8'h39) begin
			char_is_hex = 1'b1;
			char_nibble = char_q[3:0];
		end else if (char_q >= 8'h61 && char_q <= 8'h66) begin
			char_is_hex = 1'b1;
			// 'a' has low nibble 1
			char_nibble = char_q[3:0] + 4'h9;
		end
	end

	assign info = '{strobe: strobe_q, code: char_code, is_hex: char_is_hex, nibble: char_nibble};

endmodule

//--- hdl/mon_cmd_fsm.sv
`timescale 1ns/10ps

module mon_cmd_fsm #(
	parameter int START_DELAY = 3
) (
	input  logic clk,
	input  logic rst_n,
	input  mon_pkg::char_info_t info,
	input  logic word_valid,
	input  logic dump_running,
	input  logic cpu_run_state,
	input  logic bp_hit,
	output logic collect,
	output logic word_start,
	output logic bp_load,
	output mon_pkg::mon_event_t events,
	output logic pc_print_sel,
	output logic cpu_start
);
	import mon_pkg::*;

	mon_state_t state;
	mon_state_t state_next;
	logic is_quit;
	logic is_crlf;
	logic is_pc_cmd;
	logic run_break;
	logic quit_pulse;
	logic go_done;
	logic wr_addr_done;
	logic rd_end_done;
	logic stop_done;
	logic [START_DELAY-1:0] go_dly;

	// states that take hex digits
	function automatic logic is_entry(input mon_state_t s);
		return s inside {st_go_addr, st_wr_addr, st_wr_data, st_rd_start, st_rd_end,
			st_stop_addr};
	endfunction

	assign is_quit = info.strobe && (info.code == cmd_quit);
	assign is_crlf = info.strobe && (info.code == cmd_crlf);
	assign is_pc_cmd = info.strobe && (info.code == cmd_print_pc);
	assign run_break = (state == st_go_run) && bp_hit;

	always_comb begin
		state_next = state;
		if (is_quit) begin
			state_next = st_idle;
		end else begin
			case (state)
				st_idle: begin
					// letters are only taken here
					if (info.strobe) begin
						case (info.code)
							cmd_go:       state_next = st_go_addr;
							cmd_write:    state_next = st_wr_addr;
							cmd_read:     state_next = st_rd_start;
							cmd_stop:     state_next = st_stop_addr;
							cmd_print_pc: state_next = st_pc_print;
							default:      state_next = st_idle;
						endcase
					end
				end
				st_go_addr:   if (word_valid) state_next = st_go_run;
				st_go_run:    if (run_break) state_next = st_idle;
				st_wr_addr:   if (word_valid) state_next = st_wr_data;
				st_wr_data:   state_next = st_wr_data;
				st_rd_start:  if (word_valid) state_next = st_rd_end;
				st_rd_end:    if (word_valid) state_next = st_rd_dump;
				st_rd_dump:   if (!dump_running) state_next = st_idle;
				st_pc_print:  if (!dump_running) state_next = st_idle;
				st_stop_addr: if (word_valid) state_next = st_idle;
				default:      state_next = st_idle;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_idle;
		end else begin
			state <= state_next;
		end
	end

	// completed-number transitions
	assign go_done = (state == st_go_addr) && (state_next == st_go_run);
	assign wr_addr_done = (state == st_wr_addr) && (state_next == st_wr_data);
	assign rd_end_done = (state == st_rd_end) && (state_next == st_rd_dump);
	assign stop_done = (state == st_stop_addr) && word_valid && !is_quit;

	assign quit_pulse = is_quit || run_break;

	assign collect = is_entry(state);
	assign word_start = (state == st_idle) && is_entry(state_next);
	assign bp_load = stop_done;
	assign pc_print_sel = (state == st_pc_print);

	always_comb begin
		events.write_address_set = (state == st_wr_addr) && word_valid;
		events.write_data_en = (state == st_wr_data) && word_valid;
		events.read_start_set = (state == st_rd_start) && word_valid;
		events.read_end_set = (state == st_rd_end) && word_valid;
		events.read_stop = (state == st_rd_dump) && is_quit;
		events.pc_print = (state == st_idle) && (state_next == st_pc_print);
		events.quit = quit_pulse;
		// line end after a finished command line
		events.crlf = go_done || wr_addr_done || rd_end_done || stop_done || quit_pulse
			|| is_crlf || (is_pc_cmd && !cpu_run_state);
	end

	// cpu start follows the go address by START_DELAY cycles
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			go_dly <= '0;
		end else begin
			go_dly <= (go_dly << 1) | (START_DELAY)'(go_done);
		end
	end

	assign cpu_start = go_dly[START_DELAY-1];

endmodule

//--- hdl/mon_hex_word.sv
`timescale 1ns/10ps

module mon_hex_word (
	input  logic clk,
	input  logic rst_n,
	input  mon_pkg::char_info_t info,
	input  logic collect,
	input  logic word_start,
	input  logic quit,
	output mon_pkg::mon_word_u word,
	output logic word_valid
);
	import mon_pkg::*;

	localparam int cnt_w = $clog2(hex_digits);

	logic [word_w-1:0] acc;
	logic [word_w-1:0] acc_next;
	logic [cnt_w-1:0] cnt;
	logic accept;
	logic last_digit;

	// digits only count inside an entry state
	assign accept = info.strobe & info.is_hex & collect;
	assign last_digit = accept & (cnt == cnt_w'(hex_digits - 1));
	assign acc_next = {acc[word_w-5:0], info.nibble};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			acc <= '0;
			cnt <= '0;
		end else if (quit || word_start) begin
			acc <= '0;
			cnt <= '0;
		end else if (accept) begin
			acc <= acc_next;
			// wrap so further digits start a new word
			if (last_digit) begin
				cnt <= '0;
			end else begin
				cnt <= cnt + 1'b1;
			end
		end
	end

	// completed word, held until the next one
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			word <= '0;
			word_valid <= 1'b0;
		end else begin
			word_valid <= last_digit;
			if (last_digit) begin
				word.raw <= acc_next;
			end
		end
	end

endmodule

//--- hdl/mon_pkg.sv
package mon_pkg;

	// word assembly
	localparam int word_w = 32;
	localparam int hex_digits = 8;

	// commands recognised by the character decoder
	typedef enum logic [2:0] {
		cmd_none     = 3'd0,
		cmd_go       = 3'd1,
		cmd_quit     = 3'd2,
		cmd_write    = 3'd3,
		cmd_read     = 3'd4,
		cmd_stop     = 3'd5,
		cmd_print_pc = 3'd6,
		cmd_crlf     = 3'd7
	} cmd_code_t;

	// monitor command states
	typedef enum logic [3:0] {
		st_idle      = 4'd0,
		st_go_addr   = 4'd1,
		st_go_run    = 4'd2,
		st_wr_addr   = 4'd3,
		st_wr_data   = 4'd4,
		st_rd_start  = 4'd5,
		st_rd_end    = 4'd6,
		st_rd_dump   = 4'd7,
		st_stop_addr = 4'd8,
		st_pc_print  = 4'd9
	} mon_state_t;

	// one received character, already classified
	typedef struct packed {
		logic strobe;
		cmd_code_t code;
		logic is_hex;
		logic [3:0] nibble;
	} char_info_t;

	// breakpoint setting as typed by the user
	typedef struct packed {
		logic [word_w-3:0] addr;
		logic reserved;
		logic disabled;
	} bp_view_t;

	typedef union packed {
		logic [word_w-1:0] raw;
		bp_view_t bp;
	} mon_word_u;

	// single-cycle pulses to the CPU control logic
	typedef struct packed {
		logic write_address_set;
		logic write_data_en;
		logic read_start_set;
		logic read_end_set;
		logic read_stop;
		logic pc_print;
		logic quit;
		logic crlf;
	} mon_event_t;

endpackage

//--- hdl/uart_monitor.sv
`timescale 1ns/10ps

module uart_monitor #(
	parameter int START_DELAY = 3
) (
	input  logic clk,
	input  logic rst_n,
	input  logic [7:0] rx_char,
	input  logic rx_valid,
	input  logic dump_running,
	input  logic cpu_run_state,
	input  logic [31:0] pc_data,
	output logic [31:0] uart_data,
	output mon_pkg::mon_event_t events,
	output logic pc_print_sel,
	output logic cpu_start,
	output logic bp_hit
);
	import mon_pkg::*;

	char_info_t info;
	mon_word_u word;
	logic word_valid;
	logic collect;
	logic word_start;
	logic bp_load;

	mon_char_decode u_char_decode (
		.clk      (clk),
		.rst_n    (rst_n),
		.rx_char  (rx_char),
		.rx_valid (rx_valid),
		.info     (info)
	);

	mon_hex_word u_hex_word (
		.clk        (clk),
		.rst_n      (rst_n),
		.info       (info),
		.collect    (collect),
		.word_start (word_start),
		.quit       (events.quit),
		.word       (word),
		.word_valid (word_valid)
	);

	mon_cmd_fsm #(
		.START_DELAY (START_DELAY)
	) u_cmd_fsm (
		.clk           (clk),
		.rst_n         (rst_n),
		.info          (info),
		.word_valid    (word_valid),
		.dump_running  (dump_running),
		.cpu_run_state (cpu_run_state),
		.bp_hit        (bp_hit),
		.collect       (collect),
		.word_start    (word_start),
		.bp_load       (bp_load),
		.events        (events),
		.pc_print_sel  (pc_print_sel),
		.cpu_start     (cpu_start)
	);

	mon_break_point u_break_point (
		.clk           (clk),
		.rst_n         (rst_n),
		.bp_load       (bp_load),
		.word          (word),
		.pc_data       (pc_data),
		.cpu_run_state (cpu_run_state),
		.bp_hit        (bp_hit)
	);

	// address and data words go out as plain words
	assign uart_data = word.raw;

endmodule

//--- list.f
hdl/mon_pkg.sv
hdl/mon_char_decode.sv
hdl/mon_hex_word.sv
hdl/mon_cmd_fsm.sv
hdl/mon_break_point.sv
hdl/uart_monitor.sv
tb/mon_checker.sv
tb/tb_uart_monitor.sv

//--- run.sh
#!/bin/sh
# compile and run with Verilator, then look for the pass line in the log
cd "$(dirname "$0")" &&
verilator --binary --timing -f list.f --top-module tb_uart_monitor -o tb_sim > build.log 2>&1 &&
./obj_dir/tb_sim > sim.log 2>&1 &&
grep -qx "TEST PASS" sim.log &&
echo "simulation passed" ||
{ echo "simulation failed, see build.log and sim.log"; exit 1; }

//--- tb/mon_checker.sv
`timescale 1ns/10ps

module mon_checker (
	input  logic clk,
	input  logic rst_n,
	input  mon_pkg::mon_event_t events,
	input  logic cpu_start,
	input  logic [31:0] uart_data,
	input  logic [31:0] pc_data,
	input  logic pc_print_sel,
	input  logic bp_hit,
	input  logic exp_push,
	input  mon_pkg::mon_event_t exp_events,
	input  logic exp_start,
	input  logic [31:0] exp_data,
	input  logic exp_use_data,
	input  int exp_gap,
	input  logic exp_use_pc,
	input  logic [31:0] exp_pc,
	input  logic sel_check_en,
	input  logic exp_sel,
	input  logic exp_hit,
	output int mismatches,
	output int unexpected,
	output int pending
);
	import mon_pkg::*;

	// one expected pulse cycle, gap 0 means any distance
	typedef struct packed {
		mon_event_t ev;
		logic start;
		logic [31:0] data;
		logic use_data;
		int gap;
		logic use_pc;
		logic [31:0] pc;
	} exp_item_t;

	exp_item_t exp_q[$];
	int cyc_since;

	always @(posedge clk) begin
		exp_item_t item;
		exp_item_t incoming;
		if (!rst_n) begin
			exp_q.delete();
			cyc_since = 0;
			mismatches = 0;
			unexpected = 0;
		end else begin
			if (exp_push) begin
				incoming = '{ev: exp_events, start: exp_start, data: exp_data,
					use_data: exp_use_data, gap: exp_gap, use_pc: exp_use_pc, pc: exp_pc};
				exp_q.push_back(incoming);
			end
			if (events != '0 || cpu_start) begin
				if (exp_q.size() == 0) begin
					unexpected++;
					$display("pulse with nothing expected at %0t: events %h, cpu_start %b",
						$time, events, cpu_start);
				end else begin
					item = exp_q.pop_front();
					if (events !== item.ev) begin
						mismatches++;
						$display("ERROR events: expected %h, got %h at %0t", item.ev, events, $time);
					end
					if (cpu_start !== item.start) begin
						mismatches++;
						$display("ERROR cpu_start: expected %h, got %h at %0t", item.start,
							cpu_start, $time);
					end
					if (item.use_data && uart_data !== item.data) begin
						mismatches++;
						$display("ERROR uart_data: expected %h, got %h at %0t", item.data,
							uart_data, $time);
					end
					// distance to the previous pulse, cpu_start delay
					if (item.gap != 0 && cyc_since + 1 != item.gap) begin
						mismatches++;
						$display("pulse came %0d cycles after the previous one instead of %0d",
							cyc_since + 1, item.gap);
					end
					if (item.use_pc && pc_data !== item.pc) begin
						mismatches++;
						$display("ERROR pc_data: expected %h, got %h at %0t", item.pc, pc_data, $time);
					end
				end
				cyc_since = 0;
			end else begin
				cyc_since++;
			end
			if (sel_check_en && pc_print_sel !== exp_sel) begin
				mismatches++;
				$display("ERROR pc_print_sel: expected %h, got %h at %0t", exp_sel, pc_print_sel,
					$time);
			end
			// breakpoint flag follows the pc walk
			if (bp_hit !== exp_hit) begin
				mismatches++;
				$display("ERROR bp_hit: expected %h, got %h at %0t", exp_hit, bp_hit, $time);
			end
		end
		pending = exp_q.size();
	end

endmodule

//--- tb/tb_uart_monitor.sv
`timescale 1ns/10ps

module tb_uart_monitor;
	import mon_pkg::*;

	localparam int start_delay = 3;
	localparam logic [31:0] lfsr_seed = 32'hf2b44558;
	// characters sent by all tests together
	localparam int test_chars = 148;
	localparam int cycle_limit = test_chars * 4 + 200;
	localparam logic [7:0] ch_go = 8'h67;
	localparam logic [7:0] ch_quit = 8'h03;
	localparam logic [7:0] ch_write = 8'h77;
	localparam logic [7:0] ch_read = 8'h72;
	localparam logic [7:0] ch_stop = 8'h73;
	localparam logic [7:0] ch_pc = 8'h6a;
	localparam logic [7:0] ch_cr = 8'h0d;
	// letters and symbols that are no command
	localparam logic [127:0] filler = "hiklmnopqtuvxyz!";

	logic clk = 1'b0;
	logic rst_n;
	logic [7:0] rx_char;
	logic rx_valid, dump_running, cpu_run_state, pc_print_sel, cpu_start, bp_hit;
	logic [31:0] pc_data, uart_data, exp_data, exp_pc;
	mon_event_t events, exp_events;
	logic exp_push, exp_start, exp_use_data, exp_use_pc, sel_check_en, exp_sel, exp_hit;
	int exp_gap, mismatches, unexpected, pending;
	logic [31:0] lfsr_q;
	int cycles = 0;

	uart_monitor #(.START_DELAY(start_delay)) dut (.*);

	mon_checker u_checker (.*);

	always #50 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("TEST FAIL");
			$finish;
		end
	end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [7:0] hex_char(input logic [3:0] n);
		if (n < 4'd10) begin
			return 8'h30 + {4'h0, n};
		end
		// 'a' minus ten
		return 8'h57 + {4'h0, n};
	endfunction

	// expected pulses for the idx-th word of a command, or for a single character
	function automatic mon_event_t ref_event(input logic [7:0] cmd, input int idx,
		input logic dumping);
		mon_event_t ev;
		ev = '0;
		case (cmd)
			ch_write: begin
				ev.write_address_set = (idx == 0);
				ev.write_data_en = (idx != 0);
				ev.crlf = (idx == 0);
			end
			ch_read: begin
				ev.read_start_set = (idx == 0);
				ev.read_end_set = (idx != 0);
				ev.crlf = (idx != 0);
			end
			ch_go, ch_stop, ch_cr: ev.crlf = 1'b1;
			ch_pc: begin
				ev.pc_print = 1'b1;
				ev.crlf = 1'b1;
			end
			ch_quit: begin
				ev.quit = 1'b1;
				ev.crlf = 1'b1;
				ev.read_stop = dumping;
			end
			default: ev = '0;
		endcase
		return ev;
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_next(lfsr_q);
			v = {v[30:0], lfsr_q[0]};
		end
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic send_char(input logic [7:0] c);
		rx_char = c;
		rx_valid = 1'b1;
		@(posedge clk);
		#1;
		rx_valid = 1'b0;
	endtask

	task automatic type_word(input logic [31:0] w);
		for (int i = 7; i >= 0; i--) send_char(hex_char(w[i*4 +: 4]));
	endtask

	task automatic push_exp(input mon_event_t ev, input logic start, input logic [31:0] data,
		input logic use_data, input int gap, input logic use_pc, input logic [31:0] pc);
		exp_events = ev;
		exp_start = start;
		exp_data = data;
		exp_use_data = use_data;
		exp_gap = gap;
		exp_use_pc = use_pc;
		exp_pc = pc;
		exp_push = 1'b1;
		@(posedge clk);
		#1;
		exp_push = 1'b0;
	endtask

	task automatic word_pulse(input logic [7:0] cmd, input int idx, input logic [31:0] data);
		push_exp(ref_event(cmd, idx, 1'b0), 1'b0, data, 1'b1, 0, 1'b0, '0);
	endtask

	task automatic bare_pulse(input mon_event_t ev);
		push_exp(ev, 1'b0, '0, 1'b0, 0, 1'b0, '0);
	endtask

	task automatic write_burst();
		logic [31:0] addr;
		logic [31:0] data [3];
		take_bits(32, addr);
		for (int i = 0; i < 3; i++) take_bits(32, data[i]);
		word_pulse(ch_write, 0, addr);
		for (int i = 0; i < 3; i++) word_pulse(ch_write, i + 1, data[i]);
		bare_pulse(ref_event(ch_quit, 0, 1'b0));
		send_char(ch_write);
		type_word(addr);
		for (int i = 0; i < 3; i++) type_word(data[i]);
		// last data word completes before the quit
		idle(3);
		send_char(ch_quit);
		idle(4);
	endtask

	task automatic read_range();
		logic [31:0] lo_addr, hi_addr;
		dump_running = 1'b1;
		take_bits(32, lo_addr);
		take_bits(32, hi_addr);
		word_pulse(ch_read, 0, lo_addr);
		word_pulse(ch_read, 1, hi_addr);
		bare_pulse(ref_event(ch_quit, 0, 1'b1));
		send_char(ch_read);
		type_word(lo_addr);
		type_word(hi_addr);
		idle(3);
		send_char(ch_quit);
		idle(4);
		// second pass, the dump ends by itself
		dump_running = 1'b0;
		take_bits(32, lo_addr);
		take_bits(32, hi_addr);
		word_pulse(ch_read, 0, lo_addr);
		word_pulse(ch_read, 1, hi_addr);
		bare_pulse(ref_event(ch_pc, 0, 1'b0));
		send_char(ch_read);
		type_word(lo_addr);
		type_word(hi_addr);
		idle(3);
		send_char(ch_pc);
		idle(4);
	endtask

	task automatic go_and_start();
		logic [31:0] addr;
		take_bits(32, addr);
		word_pulse(ch_go, 0, addr);
		push_exp('0, 1'b1, '0, 1'b0, start_delay, 1'b0, '0);
		bare_pulse(ref_event(ch_quit, 0, 1'b0));
		send_char(ch_go);
		type_word(addr);
		idle(start_delay + 4);
		send_char(ch_quit);
		idle(4);
	endtask

	task automatic stop_address_run(input logic disabled);
		logic [31:0] stop, addr, stop_pc;
		take_bits(32, stop);
		take_bits(32, addr);
		stop[0] = disabled;
		stop_pc = {stop[31:2], 2'b00};
		word_pulse(ch_stop, 0, stop);
		word_pulse(ch_go, 0, addr);
		push_exp('0, 1'b1, '0, 1'b0, start_delay, 1'b0, '0);
		if (!disabled) begin
			push_exp(ref_event(ch_quit, 0, 1'b0), 1'b0, '0, 1'b0, 0, 1'b1, stop_pc);
		end
		send_char(ch_stop);
		type_word(stop);
		// back in idle before the next letter
		idle(2);
		send_char(ch_go);
		type_word(addr);
		idle(start_delay + 4);
		// pc walks across the stop address one word at a time
		cpu_run_state = 1'b1;
		for (int k = -4; k <= 2; k++) begin
			pc_data = stop_pc + k * 4;
			// hit only on the stop word while enabled
			exp_hit = (k == 0) && !disabled;
			@(posedge clk);
			#1;
		end
		cpu_run_state = 1'b0;
		pc_data = '0;
		exp_hit = 1'b0;
		if (disabled) begin
			bare_pulse(ref_event(ch_quit, 0, 1'b0));
			send_char(ch_quit);
		end
		idle(4);
	endtask

	task automatic print_and_line_end();
		logic [31:0] v;
		dump_running = 1'b1;
		bare_pulse(ref_event(ch_pc, 0, 1'b0));
		send_char(ch_pc);
		idle(2);
		exp_sel = 1'b1;
		sel_check_en = 1'b1;
		idle(4);
		sel_check_en = 1'b0;
		dump_running = 1'b0;
		idle(3);
		exp_sel = 1'b0;
		sel_check_en = 1'b1;
		idle(2);
		sel_check_en = 1'b0;
		bare_pulse(ref_event(ch_cr, 0, 1'b0));
		send_char(ch_cr);
		idle(3);
		// idle noise, no pulse allowed
		for (int n = 0; n < 12; n++) begin
			take_bits(5, v);
			if (v[4]) begin
				send_char(hex_char(v[3:0]));
			end else begin
				send_char(filler[8 * int'(v[3:0]) +: 8]);
			end
			idle(2);
		end
	endtask

	task automatic quit_mid_word();
		logic [31:0] part, addr;
		take_bits(20, part);
		take_bits(32, addr);
		bare_pulse(ref_event(ch_quit, 0, 1'b0));
		word_pulse(ch_write, 0, addr);
		bare_pulse(ref_event(ch_quit, 0, 1'b0));
		send_char(ch_write);
		for (int i = 4; i >= 0; i--) send_char(hex_char(part[i*4 +: 4]));
		send_char(ch_quit);
		send_char(ch_write);
		type_word(addr);
		idle(3);
		send_char(ch_quit);
		idle(4);
	endtask

	initial begin
		rst_n = 1'b0;
		rx_char = 8'h00;
		rx_valid = 1'b0;
		dump_running = 1'b0;
		cpu_run_state = 1'b0;
		pc_data = '0;
		exp_push = 1'b0;
		exp_events = '0;
		exp_start = 1'b0;
		exp_data = '0;
		exp_use_data = 1'b0;
		exp_gap = 0;
		exp_use_pc = 1'b0;
		exp_pc = '0;
		sel_check_en = 1'b0;
		exp_sel = 1'b0;
		exp_hit = 1'b0;
		lfsr_q = lfsr_seed;
		repeat (10) @(posedge clk);
		#1;
		rst_n = 1'b1;
		idle(2);
		write_burst();
		read_range();
		go_and_start();
		stop_address_run(1'b0);
		stop_address_run(1'b1);
		print_and_line_end();
		quit_mid_word();
		idle(10);
		$display("checks done: %0d mismatches, %0d unexpected pulses, %0d expected pulses missing",
			mismatches, unexpected, pending);
		if (mismatches == 0 && unexpected == 0 && pending == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule
